//--- Bender.yml
package:
  name: miniCore

sources:
  - mbPkg.sv
  - ctrlBus.sv
  - pipeCtrl.sv
  - regFile.sv
  - operandSelect.sv
  - aluUnit.sv
  - memWriteback.sv
  - miniCore.sv
  - target: simulation
    files:
      - miniCore_tb.sv

//--- aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
  input  wire               gclk,
  input  wire               reset,
  input  wire               stepEn,
  ctrlBus.dp                bus,
  input  wire mbPkg::word_t opA,
  input  wire mbPkg::word_t opB,
  output mbPkg::word_t      exResult
);
  import mbPkg::*;

  word_t addSum;
  word_t logicRes;
  word_t shiftRes;
  word_t result;

  assign addSum = opA + opB;

  always_comb begin
    case (bus.logicFn)
      OpAnd[1:0]: logicRes = opA & opB;
      OpXor[1:0]: logicRes = opA ^ opB;
      default:    logicRes = opA | opB;
    endcase
  end

  // One bit right, fill depends on shiftFn
  assign shiftRes = {bus.shiftFn ? 1'b0 : opA[31], opA[31:1]};

  always_comb begin
    case (bus.aluOp)
      AluAdd:   result = addSum;
      AluSub:   result = opB - opA;        // Reversed subtract
      AluLogic: result = logicRes;
      AluShift: result = shiftRes;
      AluMove: begin
        // Memory ops reuse move as the address adder
        if (bus.logicFn[0])
          result = addSum;
        else
          result = opB;
      end
      default:  result = addSum;
    endcase
  end

  always_ff @(posedge gclk) begin
    if (reset)
      exResult <= '0;
    else if (stepEn)
      exResult <= result;                  // Step 1
  end

endmodule

`default_nettype wire

//--- ctrlBus.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlBus;
  import mbPkg::*;

  // Execute window, registered at step 0
  srcSel_e  srcA;
  srcSel_e  srcB;
  logic     useImm;
  logic     prefixValid;    // Upper half latched for the next immediate
  aluOp_e   aluOp;
  logicFn_t logicFn;
  logic     shiftFn;        // Set for logical shift

  // Memory window, registered at step 1
  dstSel_e  exDst;
  logic     exStore;

  // Write-back, registered at step 2
  dstSel_e  wbDst;
  regIdx_t  wbReg;
  logic     wbEn;           // Stage holds an instruction

  modport ctrl (
    output srcA, srcB, useImm, prefixValid,
    output aluOp, logicFn, shiftFn,
    output exDst, exStore,
    output wbDst, wbReg, wbEn
  );

  modport dp (
    input srcA, srcB, useImm, prefixValid,
    input aluOp, logicFn, shiftFn,
    input exDst, exStore,
    input wbDst, wbReg, wbEn
  );

endinterface

`default_nettype wire

//--- mbPkg.sv
`default_nettype none

package mbPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [15:0] imm16_t;
  typedef logic [1:0]  logicFn_t;

  // Operand source, immediate only on B
  typedef enum logic [1:0] {
    SrcReg,
    SrcEx,
    SrcWb,
    SrcImm
  } srcSel_e;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluLogic,
    AluShift,
    AluMove
  } aluOp_e;

  // Write-back source
  typedef enum logic [1:0] {
    DstAlu,
    DstLoad,
    DstNone
  } dstSel_e;

  // Major opcodes, bit 3 marks the immediate form
  localparam opcode_t OpAdd   = 6'o00;
  localparam opcode_t OpRsub  = 6'o01;
  localparam opcode_t OpAddi  = 6'o10;
  localparam opcode_t OpRsubi = 6'o11;
  localparam opcode_t OpOr    = 6'o40;
  localparam opcode_t OpAnd   = 6'o41;
  localparam opcode_t OpXor   = 6'o42;
  localparam opcode_t OpShift = 6'o44;  // sra and srl, low field bit 6 picks
  localparam opcode_t OpImm   = 6'o54;  // immediate prefix
  localparam opcode_t OpLw    = 6'o62;  // also matches the offset form
  localparam opcode_t OpSw    = 6'o76;  // offset form only

endpackage

`default_nettype wire

//--- memWriteback.sv
`timescale 1ns/1ns
`default_nettype none

module memWriteback #(
  parameter int DataWidth = 32,
  parameter int AddrWidth = 10
) (
  input  wire                 gclk,
  input  wire                 reset,
  input  wire                 stepEn,
  ctrlBus.dp                  bus,
  input  wire mbPkg::word_t   exResult,
  input  wire mbPkg::word_t   storeData,
  output logic [AddrWidth-1:0] dmemAddr,
  output logic [DataWidth-1:0] dmemWrData,
  output logic                dmemStore,
  output logic                dmemLoad,
  input  wire [DataWidth-1:0] dmemRdData,
  output logic                wbValid,
  output mbPkg::regIdx_t      wbReg,
  output mbPkg::word_t        wbData
);
  import mbPkg::*;

  // Word address from the byte address
  assign dmemAddr  = exResult[AddrWidth+1:2];
  assign dmemStore = bus.exStore;
  assign dmemLoad  = (bus.exDst == DstLoad);

  // Store data follows the address into the memory window
  always_ff @(posedge gclk) begin
    if (stepEn)
      dmemWrData <= DataWidth'(storeData);
  end

  always_ff @(posedge gclk) begin
    if (reset) begin
      wbData <= '0;
    end else if (stepEn) begin
      if (bus.exDst == DstLoad)
        wbData <= word_t'(dmemRdData);   // Step 2 capture
      else
        wbData <= exResult;
    end
  end

  assign wbValid = bus.wbEn && (bus.wbDst != DstNone);
  assign wbReg   = bus.wbReg;

endmodule

`default_nettype wire

//--- miniCore.f
mbPkg.sv
ctrlBus.sv
pipeCtrl.sv
regFile.sv
operandSelect.sv
aluUnit.sv
memWriteback.sv
miniCore.sv
miniCore_tb.sv

//--- miniCore.sv
`timescale 1ns/1ns
`default_nettype none

module miniCore #(
  parameter int DataWidth = 32,
  parameter int AddrWidth = 10
) (
  input  wire                  gclk,
  input  wire                  reset,
  input  wire                  stepEn,
  input  wire mbPkg::word_t    instr,
  input  wire                  instrValid,
  output logic [AddrWidth-1:0] dmemAddr,
  output logic [DataWidth-1:0] dmemWrData,
  output logic                 dmemStore,
  output logic                 dmemLoad,
  input  wire [DataWidth-1:0]  dmemRdData,
  output logic                 wbValid,
  output mbPkg::regIdx_t       wbReg,
  output mbPkg::word_t         wbData
);
  import mbPkg::*;

  regIdx_t rdA;
  regIdx_t rdB;
  word_t   dataA;
  word_t   dataB;
  word_t   opA;
  word_t   opB;
  word_t   storeData;
  word_t   exResult;
  word_t   exFwd;

  ctrlBus bus ();

  // Load at distance 1 forwards the memory read
  assign exFwd = dmemLoad ? word_t'(dmemRdData) : exResult;

  pipeCtrl uCtrl (
    .gclk(gclk), .reset(reset), .stepEn(stepEn),
    .instr(instr), .instrValid(instrValid),
    .bus(bus.ctrl),
    .rdA(rdA), .rdB(rdB)
  );

  regFile uRegs (
    .gclk(gclk), .reset(reset),
    .rdA(rdA), .rdB(rdB),
    .dataA(dataA), .dataB(dataB),
    .wrEn(wbValid), .wrReg(wbReg), .wrData(wbData)
  );

  operandSelect uOps (
    .gclk(gclk), .reset(reset), .stepEn(stepEn),
    .bus(bus.dp),
    .imm(instr[15:0]),
    .dataA(dataA), .dataB(dataB),
    .exResult(exFwd), .wbResult(wbData),
    .opA(opA), .opB(opB), .storeData(storeData)
  );

  aluUnit uAlu (
    .gclk(gclk), .reset(reset), .stepEn(stepEn),
    .bus(bus.dp),
    .opA(opA), .opB(opB),
    .exResult(exResult)
  );

  memWriteback #(
    .DataWidth(DataWidth),
    .AddrWidth(AddrWidth)
  ) uMemWb (
    .gclk(gclk), .reset(reset), .stepEn(stepEn),
    .bus(bus.dp),
    .exResult(exResult), .storeData(storeData),
    .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
    .dmemStore(dmemStore), .dmemLoad(dmemLoad),
    .dmemRdData(dmemRdData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

`default_nettype wire

//--- miniCore_patterns.txt
// instr    kind  reg/addr  value
// kind 0 no result, 1 write-back to reg, 2 store to word address, f end of program
20200064 1 01 00000064
2040FFFD 1 02 FFFFFFFD
80000000 0 00 00000000
00611000 1 03 00000061
04811000 1 04 FFFFFF99
80A30800 1 05 00000065
84C42800 1 06 00000001
88E51000 1 07 FFFFFF98
91020000 1 08 FFFFFFFE
91220040 1 09 7FFFFFFE
B0001234 0 00 00000000
21405678 1 0A 12345678
214A8000 1 0A 1233D678
242A0000 1 01 EDCC2988
F9400040 2 10 1233D678
F8200044 2 11 EDCC2988
E8400040 1 02 1233D678
20620001 1 03 1233D679
E8800044 1 04 EDCC2988
80000000 0 00 00000000
00A41800 1 05 00000001
20010007 0 00 00000000
20C00000 1 06 00000000
E8E00080 1 07 A5020020
80000000 0 00 00000000
05073000 1 08 5AFDFFE0
00000000 f 00 00000000

//--- miniCore_tb.sv
`timescale 1ns/1ns
`default_nettype none

module miniCore_tb;
  import mbPkg::*;

  localparam int DataWidth = 32;
  localparam int AddrWidth = 10;
  localparam int Timeout   = 200;   // Falling edges allowed per result
  localparam int PatWords  = 512;

  logic                 gclk;
  logic                 reset;
  logic                 stepEn;
  word_t                instr;
  logic                 instrValid;
  logic [AddrWidth-1:0] dmemAddr;
  logic [DataWidth-1:0] dmemWrData;
  logic [DataWidth-1:0] dmemRdData;
  logic                 dmemStore;
  logic                 dmemLoad;
  logic                 wbValid;
  regIdx_t              wbReg;
  word_t                wbData;

  word_t       mem [1024];          // Data memory model
  word_t       pat [PatWords];
  logic [15:0] lfsr;
  logic        stepped;             // Last rising edge moved the pipeline
  logic        allDone;
  int          errors;
  int          passes;

  // Expected and observed results, in program order
  int    expTest[$];
  int    expKind[$];
  word_t expA[$];
  word_t expB[$];
  int    obsKind[$];
  word_t obsA[$];
  word_t obsB[$];

  miniCore #(
    .DataWidth(DataWidth),
    .AddrWidth(AddrWidth)
  ) u_dut (
    .gclk(gclk), .reset(reset), .stepEn(stepEn),
    .instr(instr), .instrValid(instrValid),
    .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
    .dmemStore(dmemStore), .dmemLoad(dmemLoad),
    .dmemRdData(dmemRdData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  initial gclk = 1'b0;
  always #20 gclk = ~gclk;

  // Combinational read, unknown data outside a load
  assign dmemRdData = dmemLoad ? mem[dmemAddr] : 'x;

  always @(posedge gclk) begin
    if (dmemStore)
      mem[dmemAddr] <= dmemWrData;
    stepped <= stepEn && !reset;
  end

  // A new result window opens after each enabled edge; write-back is the older one
  always @(negedge gclk) begin
    if (stepped) begin
      if (wbValid) begin
        obsKind.push_back(1);
        obsA.push_back(word_t'(wbReg));
        obsB.push_back(wbData);
      end
      if (dmemStore) begin
        obsKind.push_back(2);
        obsA.push_back(word_t'(dmemAddr));
        obsB.push_back(dmemWrData);
      end
    end
  end

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeBit(output logic b);
    lfsr = lfsrNext(lfsr);
    b = lfsr[0];
  endtask

  task automatic checkWriteback(input int testNo, input regIdx_t gotReg, input word_t gotData,
                                input regIdx_t expReg, input word_t expData);
    if (gotReg !== expReg || gotData !== expData) begin
      errors++;
      $display("error at %0t ns: test %0d expected r%0d = %h, got r%0d = %h",
               $time, testNo, expReg, expData, gotReg, gotData);
    end else begin
      passes++;
      $display("test %0d ok: r%0d = %h", testNo, gotReg, gotData);
    end
  endtask

  task automatic checkStore(input int testNo, input word_t gotAddr, input word_t gotData,
                            input word_t expAddr, input word_t expData);
    if (gotAddr !== expAddr || gotData !== expData) begin
      errors++;
      $display("error at %0t ns: test %0d expected store %h to %h, got %h to %h",
               $time, testNo, expData, expAddr, gotData, gotAddr);
    end else begin
      passes++;
      $display("test %0d ok: store %h to word %h", testNo, gotData, gotAddr);
    end
  endtask

  task automatic checkIdle(input logic wbV, input logic st, input logic ld);
    if (wbV !== 1'b0 || st !== 1'b0 || ld !== 1'b0) begin
      errors++;
      $display("error at %0t ns: after reset wbValid %b dmemStore %b dmemLoad %b",
               $time, wbV, st, ld);
    end else begin
      passes++;
      $display("reset ok: no write-back or memory strobe");
    end
  endtask

  // Presents the program with random stalls until the checks are over
  task automatic runFeeder();
    int   idx;
    int   stallLeft;
    logic b0;
    logic b1;
    logic b2;
    logic b3;
    idx = 0;
    stallLeft = 0;
    while (!allDone) begin
      @(negedge gclk);
      if (stallLeft > 0) begin
        stepEn = 1'b0;
        stallLeft--;
      end else begin
        takeBit(b0);
        takeBit(b1);
        if (b0 && b1) begin
          takeBit(b2);
          takeBit(b3);
          stallLeft = {b2, b3};
          stepEn = 1'b0;
        end else begin
          stepEn = 1'b1;
        end
      end
      if (stepEn) begin
        if (pat[idx*4+1] !== 32'hf) begin
          instr = pat[idx*4];
          instrValid = 1'b1;
          idx++;
        end else begin
          instr = '0;
          instrValid = 1'b0;
        end
      end
    end
  endtask

  initial begin
    int  t;
    int  k;
    int  cycles;
    int  kind;
    bit  found;
    bit  timedOut;
    word_t gotA;
    word_t gotB;
    reset = 1'b1;
    stepEn = 1'b0;
    instr = '0;
    instrValid = 1'b0;
    lfsr = 16'd83;
    allDone = 1'b0;
    errors = 0;
    passes = 0;
    found = 1'b0;
    timedOut = 1'b0;
    for (int i = 0; i < 1024; i++)
      mem[i] = 32'hA5000000 | (word_t'(i) << 12) | word_t'(i);
    $readmemh("miniCore_patterns.txt", pat);

    for (t = 0; t < PatWords / 4; t++) begin
      if (pat[t*4+1] === 32'hf) begin
        found = 1'b1;
        break;
      end
      if (pat[t*4+1] == 32'd1 || pat[t*4+1] == 32'd2) begin
        expTest.push_back(t + 1);
        expKind.push_back(int'(pat[t*4+1]));
        expA.push_back(pat[t*4+2]);
        expB.push_back(pat[t*4+3]);
      end
    end

    if (!found) begin
      errors++;
      $display("pattern file is missing its end marker");
    end else begin
      repeat (2) @(posedge gclk);
      @(negedge gclk);
      reset = 1'b0;
      #1;
      checkIdle(wbValid, dmemStore, dmemLoad);

      fork
        runFeeder();
      join_none

      for (k = 0; k < expTest.size() && !timedOut; k++) begin
        cycles = 0;
        while (obsKind.size() == 0 && cycles < Timeout) begin
          @(negedge gclk);
          #1;
          cycles++;
        end
        if (obsKind.size() == 0) begin
          errors++;
          timedOut = 1'b1;
          $display("timeout: no write-back or store seen for test %0d", expTest[k]);
        end else begin
          kind = obsKind.pop_front();
          gotA = obsA.pop_front();
          gotB = obsB.pop_front();
          if (kind != expKind[k]) begin
            errors++;
            $display("error at %0t ns: test %0d expected %s, saw %s", $time, expTest[k],
                     expKind[k] == 1 ? "a write-back" : "a store",
                     kind == 1 ? "a write-back" : "a store");
          end else if (kind == 1) begin
            checkWriteback(expTest[k], regIdx_t'(gotA), gotB, regIdx_t'(expA[k]), expB[k]);
          end else begin
            checkStore(expTest[k], gotA, gotB, expA[k], expB[k]);
          end
        end
      end

      // Nothing more may come out of the pipeline
      if (!timedOut) begin
        repeat (12) @(negedge gclk);
        #1;
        if (obsKind.size() != 0) begin
          errors++;
          $display("error at %0t ns: %0d unexpected results after the last test",
                   $time, obsKind.size());
        end
      end
    end
    allDone = 1'b1;

    $display("checks: %0d passed, %0d failed", passes, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- operandSelect.sv
`timescale 1ns/1ns
`default_nettype none

module operandSelect (
  input  wire                gclk,
  input  wire                reset,
  input  wire                stepEn,
  ctrlBus.dp                 bus,
  input  wire mbPkg::imm16_t imm,
  input  wire mbPkg::word_t  dataA,
  input  wire mbPkg::word_t  dataB,
  input  wire mbPkg::word_t  exResult,
  input  wire mbPkg::word_t  wbResult,
  output mbPkg::word_t       opA,
  output mbPkg::word_t       opB,
  output mbPkg::word_t       storeData
);
  import mbPkg::*;

  imm16_t immHi;     // Prefix latch
  word_t  immExt;    // Immediate of the executing instruction
  word_t  fwdB;

  always_ff @(posedge gclk) begin
    if (reset) begin
      immHi  <= '0;
      immExt <= '0;
    end else if (stepEn) begin
      if (!bus.prefixValid)
        immHi <= imm;                // Frozen while a prefix waits
      immExt <= bus.prefixValid ? {immHi, imm} : {{16{imm[15]}}, imm};
    end
  end

  function automatic word_t pick(srcSel_e sel, word_t regVal);
    word_t val;
    case (sel)
      SrcEx:   val = exResult;
      SrcWb:   val = wbResult;
      SrcImm:  val = immExt;
      default: val = regVal;
    endcase
    return val;
  endfunction

  assign opA       = pick(bus.srcA, dataA);
  assign fwdB      = pick(bus.srcB, dataB);
  assign opB       = bus.useImm ? immExt : fwdB;
  assign storeData = fwdB;           // rd for stores

endmodule

`default_nettype wire

//--- pipeCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCtrl (
  input  wire                gclk,
  input  wire                reset,
  input  wire                stepEn,
  input  wire mbPkg::word_t  instr,
  input  wire                instrValid,
  ctrlBus.ctrl               bus,
  output mbPkg::regIdx_t     rdA,
  output mbPkg::regIdx_t     rdB
);
  import mbPkg::*;

  opcode_t     opc;
  regIdx_t     rd;
  regIdx_t     ra;
  regIdx_t     rb;
  logic [10:0] lowField;

  logic isArith;
  logic isLogic;
  logic isShift;
  logic isPrefix;
  logic isLoad;
  logic isStore;

  dstSel_e  newDst;
  aluOp_e   newAluOp;
  logicFn_t newLogicFn;

  // Stage state
  logic    decValid;
  dstSel_e decDst;
  regIdx_t decReg;
  logic    decStore;
  logic    exValid;
  regIdx_t exReg;

  assign {opc, rd, ra, rb, lowField} = instr;

  assign isArith  = (opc == OpAdd) || (opc == OpRsub) ||
                    (opc == OpAddi) || (opc == OpRsubi);
  assign isLogic  = ({opc[5:4], opc[2]} == {OpOr[5:4], OpOr[2]}) && (opc[1:0] != 2'b11);
  assign isShift  = (opc == OpShift);
  assign isPrefix = (opc == OpImm);
  assign isLoad   = ({opc[5:4], opc[2:0]} == {OpLw[5:4], OpLw[2:0]});
  assign isStore  = (opc == OpSw);

  always_comb begin
    if (rd == '0)
      newDst = DstNone;               // r0 is never written
    else if (isLoad)
      newDst = DstLoad;
    else if (isArith || isLogic || isShift)
      newDst = DstAlu;
    else
      newDst = DstNone;
  end

  always_comb begin
    newAluOp   = AluMove;
    newLogicFn = 2'b00;
    if (isArith) begin
      newAluOp = opc[0] ? AluSub : AluAdd;
    end else if (isLogic) begin
      newAluOp   = AluLogic;
      newLogicFn = opc[1:0];
    end else if (isShift) begin
      newAluOp = AluShift;
    end else if (isLoad || isStore) begin
      newLogicFn = 2'b01;             // Move adds A for the address
    end
  end

  // Nearer stage wins
  function automatic srcSel_e fwdSel(regIdx_t src);
    srcSel_e sel;
    sel = SrcReg;
    if (src != '0 && decValid && decDst != DstNone && src == decReg)
      sel = SrcEx;
    else if (src != '0 && bus.exDst != DstNone && src == exReg)
      sel = SrcWb;
    return sel;
  endfunction

  always_ff @(posedge gclk) begin
    if (reset) begin
      decValid        <= 1'b0;
      decDst          <= DstNone;
      decStore        <= 1'b0;
      exValid         <= 1'b0;
      bus.srcA        <= SrcReg;
      bus.srcB        <= SrcReg;
      bus.useImm      <= 1'b0;
      bus.prefixValid <= 1'b0;
      bus.aluOp       <= AluAdd;
      bus.logicFn     <= 2'b00;
      bus.shiftFn     <= 1'b0;
      bus.exDst       <= DstNone;
      bus.exStore     <= 1'b0;
      bus.wbDst       <= DstNone;
      bus.wbEn        <= 1'b0;
    end else if (stepEn) begin
      // Step 0 into the execute window
      decValid    <= instrValid;
      decDst      <= newDst;
      decStore    <= isStore;
      bus.srcA    <= fwdSel(ra);
      bus.srcB    <= (opc[3] && !isStore) ? SrcImm : fwdSel(isStore ? rd : rb);
      bus.useImm  <= opc[3];
      bus.aluOp   <= newAluOp;
      bus.logicFn <= newLogicFn;
      bus.shiftFn <= lowField[6];
      if (instrValid)
        bus.prefixValid <= isPrefix;  // Held across bubbles

      // Step 1, bubbles carry no destination
      exValid     <= decValid;
      bus.exDst   <= decValid ? decDst : DstNone;
      bus.exStore <= decValid && decStore;

      // Step 2
      bus.wbEn  <= exValid;
      bus.wbDst <= bus.exDst;
    end
  end

  always_ff @(posedge gclk) begin
    if (stepEn) begin
      rdA       <= ra;
      rdB       <= isStore ? rd : rb;   // Store data rides port B
      decReg    <= rd;
      exReg     <= decReg;
      bus.wbReg <= exReg;
    end
  end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  wire                 gclk,
  input  wire                 reset,
  input  wire mbPkg::regIdx_t rdA,
  input  wire mbPkg::regIdx_t rdB,
  output mbPkg::word_t        dataA,
  output mbPkg::word_t        dataB,
  input  wire                 wrEn,
  input  wire mbPkg::regIdx_t wrReg,
  input  wire mbPkg::word_t   wrData
);
  import mbPkg::*;

  localparam int NumRegs = 32;

  word_t regs [NumRegs];

  // No writes while in reset
  always_ff @(posedge gclk) begin
    if (wrEn && !reset)
      regs[wrReg] <= wrData;
  end

  // r0 hardwired to zero
  assign dataA = (rdA == '0) ? '0 : regs[rdA];
  assign dataB = (rdB == '0) ? '0 : regs[rdB];

endmodule

`default_nettype wire
